/* design/multiexp_config.svh */
`ifndef MULTIEXP_CONFIG_SVH
`define MULTIEXP_CONFIG_SVH

// word width of the FIFOs, the table and all arithmetic
`define MX_DATA_W       32

// table address width for 32 entries
`define MX_ADDR_W       5

// bases at 0..15 and exponents at 16..31
`define MX_EXP_OFFSET   16

// exponentiation units sharing the table
`define MX_N_UNITS      2

`endif

/* design/multiexp_pkg.sv */
`include "multiexp_config.svh"

package multiexp_pkg;

    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_WRITE = 4'd1,                    // next input word is the data
        OP_READ  = 4'd2,                    // one output word
        OP_RUN   = 4'd3                     // operand n gives one output word
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, GET_DATA, MEM_WAIT, RUN_WAIT, EMIT
    } dec_state_e;

    typedef enum logic [2:0] {
        U_IDLE, U_READ_BASE, U_READ_EXP, U_SQMUL, U_NEXT, U_DONE
    } unit_state_e;

    function automatic opcode_e get_opcode(input logic [`MX_DATA_W-1:0] word);
        return opcode_e'(word[31:28]);      // out-of-range codes fall to default
    endfunction

    function automatic logic [4:0] get_operand(input logic [`MX_DATA_W-1:0] word);
        return word[4:0];                   // address or n
    endfunction

endpackage

/* design/mem_if.sv */
`include "multiexp_config.svh"

interface mem_if;

    logic                   req;            // held until gnt
    logic                   we;
    logic [`MX_ADDR_W-1:0]  addr;
    logic [`MX_DATA_W-1:0]  wdata;
    logic                   gnt;            // access issued this cycle
    logic [`MX_DATA_W-1:0]  rdata;
    logic                   rvalid;         // one cycle after a read gnt

    modport client
        ( output req
        , output we
        , output addr
        , output wdata
        , input  gnt
        , input  rdata
        , input  rvalid
        );

    modport arbiter
        ( input  req
        , input  we
        , input  addr
        , input  wdata
        , output gnt
        , output rdata
        , output rvalid
        );

endinterface

/* design/table_ram.sv */
`include "multiexp_config.svh"

module table_ram
    ( input  logic                  clk
    , input  logic                  en
    , input  logic                  we
    , input  logic [`MX_ADDR_W-1:0] addr
    , input  logic [`MX_DATA_W-1:0] wdata
    , output logic [`MX_DATA_W-1:0] rdata
    );

    localparam int depth = 2 ** `MX_ADDR_W;

    logic [`MX_DATA_W-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];         // registered read port
            end
        end
    end

endmodule

/* design/mem_arbiter.sv */
`include "multiexp_config.svh"

module mem_arbiter #(
    parameter int n_clients = 3
)
    ( input  logic                  clk
    , input  logic                  arst_n
    , mem_if.arbiter                clients [n_clients]
    , output logic                  ram_en
    , output logic                  ram_we
    , output logic [`MX_ADDR_W-1:0] ram_addr
    , output logic [`MX_DATA_W-1:0] ram_wdata
    , input  logic [`MX_DATA_W-1:0] ram_rdata
    );

    localparam int idx_w = (n_clients > 1) ? $clog2(n_clients) : 1;

    logic [n_clients-1:0]   req_v;
    logic [n_clients-1:0]   we_v;
    logic [`MX_ADDR_W-1:0]  addr_v  [n_clients];
    logic [`MX_DATA_W-1:0]  wdata_v [n_clients];
    logic [n_clients-1:0]   gnt_v;
    logic                   grant_valid;
    logic [idx_w-1:0]       grant_idx;
    logic [idx_w-1:0]       last_q;         // last client granted
    logic                   rvalid_q;
    logic [idx_w-1:0]       rd_owner_q;     // who issued the pending read

    for (genvar g = 0; g < n_clients; g++) begin : g_client
        assign req_v[g]          = clients[g].req;
        assign we_v[g]           = clients[g].we;
        assign addr_v[g]         = clients[g].addr;
        assign wdata_v[g]        = clients[g].wdata;
        assign clients[g].gnt    = gnt_v[g];
        assign clients[g].rvalid = rvalid_q && (rd_owner_q == idx_w'(g));
        assign clients[g].rdata  = ram_rdata;
    end

    // search starts just after the last winner
    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant_idx   = last_q;
        for (int off = 1; off <= n_clients; off++) begin
            cand = (int'(last_q) + off) % n_clients;
            if (!grant_valid && req_v[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = idx_w'(cand);
            end
        end
    end

    always_comb begin
        gnt_v = '0;
        if (grant_valid) begin
            gnt_v[grant_idx] = 1'b1;
        end
    end

    assign ram_en    = grant_valid;
    assign ram_we    = we_v[grant_idx];
    assign ram_addr  = addr_v[grant_idx];
    assign ram_wdata = wdata_v[grant_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q     <= idx_w'(n_clients - 1);    // client 0 wins first
            rvalid_q   <= 1'b0;
            rd_owner_q <= '0;
        end else begin
            rvalid_q <= grant_valid && !ram_we;
            if (grant_valid) begin
                last_q     <= grant_idx;
                rd_owner_q <= grant_idx;
            end
        end
    end

endmodule

/* design/cmd_decoder.sv */
`include "multiexp_config.svh"

module cmd_decoder
    ( input  logic                      clk
    , input  logic                      arst_n
    , input  logic [31:0]               fifo_datai
    , input  logic                      fifo_empty
    , output logic                      fifo_rden
    , output logic [31:0]               fifo_datao
    , input  logic                      fifo_full
    , output logic                      fifo_wren
    , output logic                      start
    , output logic [4:0]                count
    , input  logic [`MX_N_UNITS-1:0]    done
    , input  logic [`MX_DATA_W-1:0]     results [`MX_N_UNITS]
    , mem_if.client                     mem
    );

    import multiexp_pkg::*;

    dec_state_e                 state_q;
    opcode_e                    op;
    logic [31:0]                cmd_q;
    logic [`MX_DATA_W-1:0]      out_q;          // word waiting for the output FIFO
    logic                       req_q;
    logic                       we_q;
    logic [`MX_ADDR_W-1:0]      addr_q;
    logic [`MX_DATA_W-1:0]      wdata_q;
    logic                       start_q;
    logic [4:0]                 count_q;
    logic [`MX_N_UNITS-1:0]     done_seen_q;    // sticky unit done flags
    logic [`MX_N_UNITS-1:0]     done_all_v;
    logic [`MX_DATA_W-1:0]      combined;

    assign op         = get_opcode(cmd_q);
    assign done_all_v = done_seen_q | done;

    // partial products multiply together mod 2^32
    always_comb begin
        combined = `MX_DATA_W'(1);
        for (int k = 0; k < `MX_N_UNITS; k++) begin
            combined = combined * results[k];
        end
    end

    // second read strobe fetches the write data
    assign fifo_rden  = !fifo_empty &&
                        (state_q == IDLE || (state_q == DECODE && op == OP_WRITE));
    assign fifo_wren  = (state_q == EMIT) && !fifo_full;
    assign fifo_datao = out_q;

    assign start      = start_q;
    assign count      = count_q;

    assign mem.req    = req_q;
    assign mem.we     = we_q;
    assign mem.addr   = addr_q;
    assign mem.wdata  = wdata_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= IDLE;
            req_q       <= 1'b0;
            we_q        <= 1'b0;
            start_q     <= 1'b0;
            done_seen_q <= '0;
        end else begin
            start_q <= 1'b0;                    // single-cycle pulse
            case (state_q)
                IDLE: begin
                    if (!fifo_empty) begin
                        state_q <= FETCH;
                    end
                end
                FETCH: begin
                    state_q <= DECODE;          // command word lands in cmd_q
                end
                DECODE: begin
                    case (op)
                        OP_WRITE: begin
                            if (!fifo_empty) begin
                                state_q <= GET_DATA;
                            end
                        end
                        OP_READ: begin
                            req_q   <= 1'b1;
                            we_q    <= 1'b0;
                            state_q <= MEM_WAIT;
                        end
                        OP_RUN: begin
                            start_q     <= 1'b1;
                            done_seen_q <= '0;
                            state_q     <= RUN_WAIT;
                        end
                        default: begin
                            state_q <= IDLE;    // nop and unknown codes dropped
                        end
                    endcase
                end
                GET_DATA: begin
                    req_q   <= 1'b1;
                    we_q    <= 1'b1;
                    state_q <= MEM_WAIT;
                end
                MEM_WAIT: begin
                    if (mem.gnt) begin
                        req_q <= 1'b0;
                        if (we_q) begin
                            state_q <= IDLE;    // writes give no output
                        end
                    end
                    if (mem.rvalid) begin
                        state_q <= EMIT;
                    end
                end
                RUN_WAIT: begin
                    if (&done_all_v) begin
                        state_q <= EMIT;
                    end else begin
                        done_seen_q <= done_all_v;
                    end
                end
                EMIT: begin
                    if (!fifo_full) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FETCH) begin
            cmd_q <= fifo_datai;
        end
        if (state_q == DECODE) begin
            addr_q  <= get_operand(cmd_q);
            count_q <= get_operand(cmd_q);
        end
        if (state_q == GET_DATA) begin
            wdata_q <= fifo_datai;
        end
        if (state_q == MEM_WAIT && mem.rvalid) begin
            out_q <= mem.rdata;
        end
        if (state_q == RUN_WAIT && &done_all_v) begin
            out_q <= combined;
        end
    end

endmodule

/* design/exp_unit.sv */
`include "multiexp_config.svh"

module exp_unit #(
    parameter int unit_id = 0
)
    ( input  logic                  clk
    , input  logic                  arst_n
    , input  logic                  start
    , input  logic [4:0]            count
    , output logic                  done
    , output logic [`MX_DATA_W-1:0] result
    , mem_if.client                 mem
    );

    import multiexp_pkg::*;

    unit_state_e            state_q;
    logic [4:0]             idx_q;          // next table index for this unit
    logic [4:0]             count_q;
    logic                   req_q;
    logic [`MX_ADDR_W-1:0]  addr_q;
    logic [`MX_DATA_W-1:0]  base_q;         // squared every step
    logic [`MX_DATA_W-1:0]  exp_q;          // shifted right every step
    logic [`MX_DATA_W-1:0]  acc_q;          // current factor
    logic [`MX_DATA_W-1:0]  prod_q;         // running partial product

    assign done      = (state_q == U_DONE);
    assign result    = prod_q;

    assign mem.req   = req_q;
    assign mem.we    = 1'b0;                // units only read
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= U_IDLE;
            idx_q   <= '0;
            req_q   <= 1'b0;
        end else begin
            case (state_q)
                U_IDLE: begin
                    if (start) begin
                        idx_q   <= 5'(unit_id);
                        state_q <= U_NEXT;
                    end
                end
                U_NEXT: begin
                    if (idx_q < count_q) begin
                        req_q   <= 1'b1;    // base read
                        idx_q   <= idx_q + 5'(`MX_N_UNITS);
                        state_q <= U_READ_BASE;
                    end else begin
                        state_q <= U_DONE;
                    end
                end
                U_READ_BASE: begin
                    if (mem.gnt) begin
                        req_q <= 1'b0;
                    end
                    if (mem.rvalid) begin
                        req_q   <= 1'b1;    // exponent read
                        state_q <= U_READ_EXP;
                    end
                end
                U_READ_EXP: begin
                    if (mem.gnt) begin
                        req_q <= 1'b0;
                    end
                    if (mem.rvalid) begin
                        state_q <= U_SQMUL;
                    end
                end
                U_SQMUL: begin
                    if (exp_q == '0) begin
                        state_q <= U_NEXT;
                    end
                end
                U_DONE: begin
                    state_q <= U_IDLE;
                end
                default: begin
                    state_q <= U_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == U_IDLE && start) begin
            count_q <= count;
            acc_q   <= `MX_DATA_W'(1);
            prod_q  <= `MX_DATA_W'(1);
        end
        if (state_q == U_NEXT) begin
            prod_q <= prod_q * acc_q;       // fold in the finished factor
            addr_q <= idx_q;
        end
        if (state_q == U_READ_BASE && mem.rvalid) begin
            base_q <= mem.rdata;
            addr_q <= addr_q + `MX_ADDR_W'(`MX_EXP_OFFSET);
        end
        if (state_q == U_READ_EXP && mem.rvalid) begin
            exp_q <= mem.rdata;
            acc_q <= `MX_DATA_W'(1);
        end
        if (state_q == U_SQMUL && exp_q != '0) begin
            if (exp_q[0]) begin
                acc_q <= acc_q * base_q;
            end
            base_q <= base_q * base_q;
            exp_q  <= exp_q >> 1;
        end
    end

endmodule

/* design/multiexp_top.sv */
`include "multiexp_config.svh"

module multiexp_top
    ( input  logic          clk
    , input  logic          arst_n
    , input  logic [31:0]   fifo_datai
    , input  logic          fifo_empty
    , output logic          fifo_rden
    , output logic [31:0]   fifo_datao
    , output logic          fifo_wren
    , input  logic          fifo_full
    );

    logic                   start;
    logic [4:0]             count;
    logic [`MX_N_UNITS-1:0] unit_done;
    logic [`MX_DATA_W-1:0]  unit_result [`MX_N_UNITS];
    logic                   ram_en;
    logic                   ram_we;
    logic [`MX_ADDR_W-1:0]  ram_addr;
    logic [`MX_DATA_W-1:0]  ram_wdata;
    logic [`MX_DATA_W-1:0]  ram_rdata;

    mem_if mem_bus [`MX_N_UNITS+1] ();      // 0 is the decoder

    cmd_decoder u_cmd_decoder
        ( .clk          (clk)
        , .arst_n       (arst_n)
        , .fifo_datai   (fifo_datai)
        , .fifo_empty   (fifo_empty)
        , .fifo_rden    (fifo_rden)
        , .fifo_datao   (fifo_datao)
        , .fifo_full    (fifo_full)
        , .fifo_wren    (fifo_wren)
        , .start        (start)
        , .count        (count)
        , .done         (unit_done)
        , .results      (unit_result)
        , .mem          (mem_bus[0])
        );

    for (genvar g = 0; g < `MX_N_UNITS; g++) begin : g_unit
        exp_unit #(.unit_id(g)) u_exp_unit
            ( .clk      (clk)
            , .arst_n   (arst_n)
            , .start    (start)
            , .count    (count)
            , .done     (unit_done[g])
            , .result   (unit_result[g])
            , .mem      (mem_bus[g+1])
            );
    end

    mem_arbiter #(.n_clients(`MX_N_UNITS + 1)) u_mem_arbiter
        ( .clk          (clk)
        , .arst_n       (arst_n)
        , .clients      (mem_bus)
        , .ram_en       (ram_en)
        , .ram_we       (ram_we)
        , .ram_addr     (ram_addr)
        , .ram_wdata    (ram_wdata)
        , .ram_rdata    (ram_rdata)
        );

    table_ram u_table_ram
        ( .clk          (clk)
        , .en           (ram_en)
        , .we           (ram_we)
        , .addr         (ram_addr)
        , .wdata        (ram_wdata)
        , .rdata        (ram_rdata)
        );

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int half_period = 10
)
    ( output logic clk
    );

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;  // 20 ns period
    end

endmodule

/* test/multiexp_tb.sv */
module multiexp_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [3:0] op_write = 4'h1;
    localparam logic [3:0] op_read  = 4'h2;
    localparam logic [3:0] op_run   = 4'h3;
    localparam int wait_limit   = 20000;    // cycles per entry
    localparam int quiet_cycles = 40;       // watch for stray words

    logic        clk;
    logic        arst_n = 1'b0;
    logic [31:0] fifo_datai = '0;
    logic        fifo_empty = 1'b1;
    logic        fifo_rden;
    logic [31:0] fifo_datao;
    logic        fifo_wren;
    logic        fifo_full = 1'b0;

    logic [31:0] in_q [$];                  // input FIFO model
    logic [31:0] out_words [$];             // everything the DUT wrote
    logic [31:0] next_word = '0;
    logic        empty_next = 1'b1;
    logic        full_next = 1'b0;
    logic        bp_on = 1'b0;
    logic [7:0]  bp_idx = '0;
    bit          full_pattern [256];
    logic [31:0] rng_state = 32'd11;
    logic [31:0] shadow [32];               // reference copy of the table

    string       entry_label [16];
    bit          entry_bp [16];
    int          entry_cmd_first [16];
    int          entry_cmd_len [16];
    int          entry_exp_first [16];
    int          entry_exp_len [16];
    logic [31:0] cmd_words [512];
    logic [31:0] exp_words [128];
    int          n_entries = 0;
    int          n_cmd = 0;
    int          n_exp = 0;
    int          mismatch_count = 0;
    int          proto_errors = 0;
    int          timeout_count = 0;

    tb_clock_gen u_clock_gen (.clk(clk));

    multiexp_top u_multiexp_top
        ( .clk          (clk)
        , .arst_n       (arst_n)
        , .fifo_datai   (fifo_datai)
        , .fifo_empty   (fifo_empty)
        , .fifo_rden    (fifo_rden)
        , .fifo_datao   (fifo_datao)
        , .fifo_wren    (fifo_wren)
        , .fifo_full    (fifo_full)
        );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // left-to-right binary power mod 2^32
    function automatic logic [31:0] power_mod(input logic [31:0] b, input logic [31:0] e);
        logic [31:0] r;
        r = 32'd1;
        for (int i = 31; i >= 0; i--) begin
            r = r * r;
            if (e[i]) begin
                r = r * b;
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] product_of_powers(input int n);
        logic [31:0] p;
        p = 32'd1;
        for (int i = 0; i < n; i++) begin
            p = p * power_mod(shadow[i], shadow[16 + i]);
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s expected %08h got %08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic open_entry(input string label, input bit bp);
        entry_label[n_entries]     = label;
        entry_bp[n_entries]        = bp;
        entry_cmd_first[n_entries] = n_cmd;
        entry_exp_first[n_entries] = n_exp;
    endtask

    task automatic close_entry();
        entry_cmd_len[n_entries] = n_cmd - entry_cmd_first[n_entries];
        entry_exp_len[n_entries] = n_exp - entry_exp_first[n_entries];
        n_entries++;
    endtask

    task automatic push_cmd(input logic [31:0] w);
        cmd_words[n_cmd] = w;
        n_cmd++;
    endtask

    task automatic push_expected(input logic [31:0] w);
        exp_words[n_exp] = w;
        n_exp++;
    endtask

    task automatic add_write(input logic [4:0] addr, input logic [31:0] data);
        push_cmd({op_write, 23'd0, addr});
        push_cmd(data);
        shadow[addr] = data;
    endtask

    task automatic add_read(input logic [4:0] addr);
        push_cmd({op_read, 23'd0, addr});
        push_expected(shadow[addr]);
    endtask

    task automatic add_run(input logic [4:0] n);
        push_cmd({op_run, 23'd0, n});
        push_expected(product_of_powers(int'(n)));
    endtask

    task automatic build_table();
        open_entry("write then read", 1'b0);
        add_write(5'd5, 32'hdead_beef);
        add_read(5'd5);
        close_entry();
        open_entry("fill and read all", 1'b0);
        for (int a = 0; a < 32; a++) begin
            add_write(5'(a), next_random());
        end
        for (int a = 0; a < 32; a++) begin
            add_read(5'(a));
        end
        close_entry();
        open_entry("run n=0", 1'b0);
        add_run(5'd0);
        close_entry();
        open_entry("run n=1 exponent 0", 1'b0);
        add_write(5'd0, next_random());
        add_write(5'd16, 32'd0);
        add_run(5'd1);
        close_entry();
        open_entry("run n=1 large exponent", 1'b0);
        add_write(5'd0, next_random() | 32'd1);
        add_write(5'd16, 32'hffff_fffb);
        add_run(5'd1);
        close_entry();
        open_entry("run n=16 random", 1'b0);
        for (int a = 0; a < 16; a++) begin
            add_write(5'(a), next_random() | 32'd1);   // odd keeps the product nonzero
            add_write(5'(16 + a), next_random());
        end
        add_run(5'd16);
        close_entry();
        open_entry("burst with back-pressure", 1'b1);
        for (int k = 0; k < 6; k++) begin
            add_write(5'(k), next_random() | 32'd1);
            add_run(5'(k + 3));
            add_read(5'(16 + k));
        end
        add_run(5'd16);
        close_entry();
        open_entry("nop and unknown opcodes", 1'b0);
        push_cmd(32'h0000_0000);
        push_cmd(32'h7000_0012);
        push_cmd(32'hf123_4567);
        push_cmd(32'h4000_0001);
        add_read(5'd1);
        push_cmd(32'h0000_0003);
        push_cmd(32'h9abc_def0);
        add_run(5'd4);
        close_entry();
        for (int k = 0; k < 256; k++) begin
            full_pattern[k] = ((next_random() % 3) == 0);  // full about a third of the time
        end
    endtask

    // FIFO models act on the rising edge and drive pins on the falling edge
    always @(posedge clk) begin
        if (fifo_rden) begin
            if (in_q.size() > 0) begin
                next_word = in_q.pop_front();
            end else begin
                proto_errors++;
                $display("Error at %0t ns: fifo_rden was high while the input FIFO was empty",
                         $time);
            end
        end
        empty_next = (in_q.size() == 0);
        full_next  = bp_on && full_pattern[bp_idx];
        bp_idx     = bp_idx + 8'd1;
        if (fifo_wren) begin
            out_words.push_back(fifo_datao);
            if (fifo_full) begin
                proto_errors++;
                $display("Error at %0t ns: fifo_wren was high while fifo_full was high", $time);
            end
        end
    end

    always @(negedge clk) begin
        fifo_datai = next_word;             // valid the cycle after rden
        fifo_empty = empty_next;
        fifo_full  = full_next;
    end

    task automatic run_entry(input int e);
        int cycles;
        int want;
        @(negedge clk);
        bp_on = entry_bp[e];
        for (int k = 0; k < entry_cmd_len[e]; k++) begin
            in_q.push_back(cmd_words[entry_cmd_first[e] + k]);
        end
        want   = entry_exp_first[e] + entry_exp_len[e];
        cycles = 0;
        while ((in_q.size() != 0 || out_words.size() < want) && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (in_q.size() != 0 || out_words.size() < want) begin
            timeout_count++;
            $display({"Timeout: entry \"%s\" is stuck with %0d input words left, ",
                      "%0d of %0d outputs"},
                     entry_label[e], in_q.size(), out_words.size() - entry_exp_first[e],
                     entry_exp_len[e]);
        end else begin
            for (int k = 0; k < quiet_cycles; k++) begin
                @(negedge clk);
            end
            bp_on = 1'b0;
            check_value($sformatf("%s fifo_wren count", entry_label[e]), 32'(want),
                        32'(out_words.size()));
            for (int k = entry_exp_first[e]; k < want && k < out_words.size(); k++) begin
                check_value($sformatf("%s fifo_datao[%0d]", entry_label[e],
                                      k - entry_exp_first[e]), exp_words[k], out_words[k]);
            end
        end
    endtask

    initial begin
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // nothing to read and nothing to write
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            check_value("fifo_rden after reset", 32'd0, {31'd0, fifo_rden});
            check_value("fifo_wren after reset", 32'd0, {31'd0, fifo_wren});
        end
        for (int e = 0; e < n_entries && timeout_count == 0; e++) begin
            run_entry(e);
        end
        $display("Summary: %0d mismatches, %0d protocol errors, %0d timeouts",
                 mismatch_count, proto_errors, timeout_count);
        if (mismatch_count + proto_errors + timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/multiexp_pkg.sv
design/mem_if.sv
design/table_ram.sv
design/mem_arbiter.sv
design/cmd_decoder.sv
design/exp_unit.sv
design/multiexp_top.sv
test/tb_clock_gen.sv
test/multiexp_tb.sv

/* run.sh */
#!/bin/sh
# build and run the multiexp testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -Wno-fatal -f flist.f --top-module multiexp_tb -o multiexp_sim \
    > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/multiexp_sim > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

if grep -qx "All tests passed" "$SIM_LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $SIM_LOG"
    exit 1
fi
